// ==== rtl/button_edge.sv ====
/*
 * Synchronises one push button to clock_25 and gives a one-cycle pulse
 * on each press. A held button produces a single pulse.
 */
`timescale 1ns/100ps

module button_edge (
    input  logic clock_25,
    input  logic reset,
    input  logic button,
    output logic pulse
);

    logic sync_q1;
    logic sync_q2;
    logic prev_q;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            prev_q  <= 1'b0;
            pulse   <= 1'b0;
        end else begin
            sync_q1 <= button;                  // Metastability stage
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
            pulse   <= sync_q2 & ~prev_q;       // Rising edge only
        end
    end

endmodule

// ==== rtl/fruit_placer.sv ====
/*
 * Fruit position, score and snake length. Two free-running LFSRs offer
 * candidate cells; a candidate off the play area or on the snake is redrawn.
 */
`timescale 1ns/100ps

module fruit_placer (
    input  logic               clock_25,
    input  logic               reset,
    input  logic               sync_reset,
    input  logic               eat_en,
    input  logic               place_en,
    input  snake_pkg::cell_t   head_x,
    input  snake_pkg::cell_t   head_y,
    input  logic               probe_on_body,
    output snake_pkg::cell_t   fruit_x,
    output snake_pkg::cell_t   fruit_y,
    output snake_pkg::score_t  score,
    output snake_pkg::length_t snake_length,
    output logic               fruit_eaten,
    output logic               misplaced
);

    import snake_pkg::*;

    cell_t lfsr_x;
    cell_t lfsr_y;

    // x^7 + x^6 + 1, period 127
    function automatic cell_t lfsr_step(input cell_t state);
        return {state[5:0], state[6] ^ state[5]};
    endfunction

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            lfsr_x <= SEED_X;
            lfsr_y <= SEED_Y;
        end else if (sync_reset) begin
            lfsr_x <= SEED_X;       // Same fruit sequence after every restart
            lfsr_y <= SEED_Y;
        end else begin
            lfsr_x <= lfsr_step(lfsr_x);
            lfsr_y <= lfsr_step(lfsr_y);
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit_x      <= cell_t'(START_FRUIT_X);
            fruit_y      <= cell_t'(START_FRUIT_Y);
            score        <= '0;
            snake_length <= length_t'(START_LENGTH);
        end else if (sync_reset) begin
            fruit_x      <= cell_t'(START_FRUIT_X);
            fruit_y      <= cell_t'(START_FRUIT_Y);
            score        <= '0;
            snake_length <= length_t'(START_LENGTH);
        end else if (eat_en) begin
            fruit_x <= lfsr_x;      // First candidate, checked in FRUIT_UPDATE
            fruit_y <= lfsr_y;
            if (score == score_t'(SCORE_WRAP)) begin
                score <= '0;
            end else begin
                score <= score + 7'd1;
            end
            if (snake_length != length_t'(LENGTH_MAX)) begin
                snake_length <= snake_length + length_t'(1);
            end
        end else if (place_en && misplaced) begin
            fruit_x <= lfsr_x;      // Redraw
            fruit_y <= lfsr_y;
        end
    end

    // Keep a one cell margin inside the walls
    assign misplaced = (fruit_x < 7'd2) || (fruit_x > cell_t'(GRID_W - 2)) ||
                       (fruit_y < 7'd2) || (fruit_y > cell_t'(GRID_H - 2)) ||
                       probe_on_body;

    assign fruit_eaten = (fruit_x == head_x) && (fruit_y == head_y);

endmodule

// ==== rtl/game_fsm.sv ====
/*
 * Moore state machine of the game. Decodes the state into the enables for
 * steering, movement, eating and fruit placement, and the start/game_over status.
 */
`timescale 1ns/100ps

module game_fsm (
    input  logic clock_25,
    input  logic reset,
    input  logic game_tik,
    input  logic turn_cw,
    input  logic turn_ccw,
    input  logic collision,
    input  logic fruit_eaten,
    input  logic misplaced,
    output logic sync_reset,
    output logic move_en,
    output logic eat_en,
    output logic place_en,
    output logic steer_en,
    output logic start,
    output logic game_over
);

    import snake_pkg::*;

    game_state_t state_q;
    game_state_t state_d;
    logic        any_press;

    assign any_press = turn_cw | turn_ccw;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            state_q <= RESET_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET_IDLE:   state_d = IDLE;
            IDLE:         if (any_press) state_d = WAIT;
            WAIT:         if (game_tik) state_d = MOVING;     // Ticks elsewhere are dropped
            MOVING:       state_d = MOVE_DONE;
            MOVE_DONE: begin
                if (collision) begin
                    state_d = COLLISION;
                end else if (fruit_eaten) begin
                    state_d = EATEN_FRUIT;
                end else begin
                    state_d = WAIT;
                end
            end
            EATEN_FRUIT:  state_d = FRUIT_UPDATE;
            FRUIT_UPDATE: if (!misplaced) state_d = WAIT;      // Redraw until the fruit fits
            COLLISION:    if (any_press) state_d = RESET_IDLE;
            default:      state_d = RESET_IDLE;
        endcase
    end

    assign sync_reset = (state_q == RESET_IDLE);
    assign move_en    = (state_q == MOVING);
    assign eat_en     = (state_q == EATEN_FRUIT);
    assign place_en   = (state_q == FRUIT_UPDATE);
    assign steer_en   = (state_q == WAIT) || (state_q == MOVING) || (state_q == MOVE_DONE) ||
                        (state_q == EATEN_FRUIT) || (state_q == FRUIT_UPDATE);
    assign start      = steer_en;                  // Game running
    assign game_over  = (state_q == COLLISION);

endmodule

// ==== rtl/snake_body.sv ====
/*
 * Head and body registers of the snake. Steps them on move_en, flags wall and
 * self collisions, checks the fruit probe and serves a random-access body read.
 */
`timescale 1ns/100ps

module snake_body (
    input  logic                               clock_25,
    input  logic                               reset,
    input  logic                               sync_reset,
    input  logic                               move_en,
    input  logic                               grow_en,
    input  snake_pkg::heading_t                step_heading,
    input  snake_pkg::length_t                 snake_length,
    input  logic [snake_pkg::LENGTH_BITS-1:0]  body_index,
    input  snake_pkg::cell_t                   probe_x,
    input  snake_pkg::cell_t                   probe_y,
    output snake_pkg::cell_t                   head_x,
    output snake_pkg::cell_t                   head_y,
    output snake_pkg::cell_t                   body_x,
    output snake_pkg::cell_t                   body_y,
    output logic                               collision,
    output logic                               probe_on_body
);

    import snake_pkg::*;

    cell_t                 body_x_reg [BODY_SLOTS];
    cell_t                 body_y_reg [BODY_SLOTS];
    cell_t                 next_x;
    cell_t                 next_y;
    logic                  step_off;        // Next step would leave the grid
    logic                  wall_hit;
    length_t               live_count;      // Body slots in use, head excluded
    logic [BODY_SLOTS-1:0] live;
    logic [BODY_SLOTS-1:0] head_hit;
    logic [BODY_SLOTS-1:0] probe_hit;

    assign live_count = snake_length - length_t'(1);

    always_comb begin
        next_x   = head_x;
        next_y   = head_y;
        step_off = 1'b0;
        case (step_heading)
            HEAD_RIGHT: begin
                step_off = (head_x == cell_t'(GRID_W - 1));
                next_x   = head_x + 7'd1;
            end
            HEAD_DOWN: begin
                step_off = (head_y == cell_t'(GRID_H - 1));   // Rows grow downward
                next_y   = head_y + 7'd1;
            end
            HEAD_LEFT: begin
                step_off = (head_x == 7'd0);
                next_x   = head_x - 7'd1;
            end
            default: begin
                step_off = (head_y == 7'd0);
                next_y   = head_y - 7'd1;
            end
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head_x   <= cell_t'(START_HEAD_X);
            head_y   <= cell_t'(START_HEAD_Y);
            wall_hit <= 1'b0;
        end else if (sync_reset) begin
            head_x   <= cell_t'(START_HEAD_X);
            head_y   <= cell_t'(START_HEAD_Y);
            wall_hit <= 1'b0;
        end else if (move_en) begin
            wall_hit <= step_off;
            if (!step_off) begin
                head_x <= next_x;
                head_y <= next_y;
            end
        end
    end

    // Body shift register, slot 0 is right behind the head
    always_ff @(posedge clock_25) begin
        if (sync_reset) begin
            for (int i = 0; i < BODY_SLOTS; i++) begin
                if (i < START_LENGTH - 1) begin
                    body_x_reg[i] <= cell_t'(START_HEAD_X - 1 - i);
                    body_y_reg[i] <= cell_t'(START_HEAD_Y);
                end else begin
                    body_x_reg[i] <= BODY_EMPTY;
                    body_y_reg[i] <= BODY_EMPTY;
                end
            end
        end else if (move_en && !step_off) begin
            body_x_reg[0] <= head_x;
            body_y_reg[0] <= head_y;
            // A grown snake picks up its new tail slot here
            for (int i = 1; i < BODY_SLOTS; i++) begin
                if (live[i]) begin
                    body_x_reg[i] <= body_x_reg[i-1];
                    body_y_reg[i] <= body_y_reg[i-1];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BODY_SLOTS; i++) begin
            live[i]      = (i < live_count);
            head_hit[i]  = live[i] && (body_x_reg[i] == head_x) && (body_y_reg[i] == head_y);
            probe_hit[i] = live[i] && (body_x_reg[i] == probe_x) && (body_y_reg[i] == probe_y);
        end
    end

    assign collision     = wall_hit | (|head_hit);
    assign probe_on_body = ((probe_x == head_x) && (probe_y == head_y)) | (|probe_hit);

    // Live count already rises on grow_en through snake_length
    assign body_x = (body_index < live_count) ? body_x_reg[body_index] : BODY_EMPTY;
    assign body_y = (body_index < live_count) ? body_y_reg[body_index] : BODY_EMPTY;

endmodule

// ==== rtl/snake_game_top.sv ====
/*
 * Top level of the snake playfield controller. Connects the button edge
 * detectors, steering, body, fruit logic and the game FSM.
 */
`timescale 1ns/100ps

module snake_game_top (
    input  logic                              clock_25,
    input  logic                              reset,
    input  logic                              game_tik,
    input  logic                              right_p,
    input  logic                              left_p,
    input  logic [snake_pkg::LENGTH_BITS-1:0] body_index,
    output logic                              start,
    output logic                              game_over,
    output snake_pkg::score_t                 score,
    output snake_pkg::cell_t                  head_x,
    output snake_pkg::cell_t                  head_y,
    output snake_pkg::cell_t                  fruit_x,
    output snake_pkg::cell_t                  fruit_y,
    output snake_pkg::cell_t                  body_x,
    output snake_pkg::cell_t                  body_y,
    output snake_pkg::length_t                snake_length,
    output snake_pkg::heading_t               heading
);

    import snake_pkg::*;

    logic     turn_cw;
    logic     turn_ccw;
    logic     sync_reset;
    logic     move_en;
    logic     eat_en;
    logic     place_en;
    logic     steer_en;
    logic     collision;
    logic     fruit_eaten;
    logic     misplaced;
    logic     probe_on_body;
    heading_t step_heading;

    button_edge u_right_edge (
        .clock_25 (clock_25),
        .reset    (reset),
        .button   (right_p),
        .pulse    (turn_cw)
    );

    button_edge u_left_edge (
        .clock_25 (clock_25),
        .reset    (reset),
        .button   (left_p),
        .pulse    (turn_ccw)
    );

    steer_control u_steer_control (
        .clock_25     (clock_25),
        .reset        (reset),
        .sync_reset   (sync_reset),
        .steer_en     (steer_en),
        .move_en      (move_en),
        .turn_cw      (turn_cw),
        .turn_ccw     (turn_ccw),
        .heading      (heading),
        .step_heading (step_heading)
    );

    snake_body u_snake_body (
        .clock_25      (clock_25),
        .reset         (reset),
        .sync_reset    (sync_reset),
        .move_en       (move_en),
        .grow_en       (eat_en),
        .step_heading  (step_heading),
        .snake_length  (snake_length),
        .body_index    (body_index),
        .probe_x       (fruit_x),        // Fruit is the only probe
        .probe_y       (fruit_y),
        .head_x        (head_x),
        .head_y        (head_y),
        .body_x        (body_x),
        .body_y        (body_y),
        .collision     (collision),
        .probe_on_body (probe_on_body)
    );

    fruit_placer u_fruit_placer (
        .clock_25      (clock_25),
        .reset         (reset),
        .sync_reset    (sync_reset),
        .eat_en        (eat_en),
        .place_en      (place_en),
        .head_x        (head_x),
        .head_y        (head_y),
        .probe_on_body (probe_on_body),
        .fruit_x       (fruit_x),
        .fruit_y       (fruit_y),
        .score         (score),
        .snake_length  (snake_length),
        .fruit_eaten   (fruit_eaten),
        .misplaced     (misplaced)
    );

    game_fsm u_game_fsm (
        .clock_25    (clock_25),
        .reset       (reset),
        .game_tik    (game_tik),
        .turn_cw     (turn_cw),
        .turn_ccw    (turn_ccw),
        .collision   (collision),
        .fruit_eaten (fruit_eaten),
        .misplaced   (misplaced),
        .sync_reset  (sync_reset),
        .move_en     (move_en),
        .eat_en      (eat_en),
        .place_en    (place_en),
        .steer_en    (steer_en),
        .start       (start),
        .game_over   (game_over)
    );

endmodule

// ==== rtl/snake_pkg.sv ====
/*
 * Shared constants and types for the snake playfield controller.
 * Every RTL block imports this package for grid sizes, start values and seeds.
 */
package snake_pkg;

    // Playfield size in cells
    localparam int GRID_W = 124;
    localparam int GRID_H = 81;

    // Snake length limits, head included
    localparam int LENGTH_BITS = 7;
    localparam int LENGTH_MAX  = 127;
    localparam int BODY_SLOTS  = LENGTH_MAX - 1;    // Head is held apart from the body

    // Values loaded on every restart
    localparam int START_HEAD_X  = 8;
    localparam int START_HEAD_Y  = 40;
    localparam int START_LENGTH  = 6;
    localparam int START_FRUIT_X = 18;
    localparam int START_FRUIT_Y = 50;

    localparam int SCORE_WRAP = 99;                 // Two digit score display

    // Fruit LFSR seeds, both non-zero
    localparam logic [6:0] SEED_X = 7'b0011100;
    localparam logic [6:0] SEED_Y = 7'b0110000;

    // Unused body slots hold an off-grid cell
    localparam logic [6:0] BODY_EMPTY = 7'd127;

    typedef logic [6:0]             cell_t;
    typedef logic [LENGTH_BITS-1:0] length_t;
    typedef logic [6:0]             score_t;

    // Clockwise order, so a right turn is +1
    typedef enum logic [1:0] {
        HEAD_RIGHT,
        HEAD_DOWN,
        HEAD_LEFT,
        HEAD_UP
    } heading_t;

    typedef enum logic [2:0] {
        IDLE         = 3'b000,
        WAIT         = 3'b001,
        COLLISION    = 3'b010,
        MOVING       = 3'b011,
        MOVE_DONE    = 3'b100,
        EATEN_FRUIT  = 3'b101,
        FRUIT_UPDATE = 3'b110,
        RESET_IDLE   = 3'b111
    } game_state_t;

endpackage

// ==== rtl/steer_control.sv ====
/*
 * Keeps the snake heading and the turn requested since the last move.
 * step_heading is the direction the next move will take.
 */
`timescale 1ns/100ps

module steer_control (
    input  logic                clock_25,
    input  logic                reset,
    input  logic                sync_reset,
    input  logic                steer_en,
    input  logic                move_en,
    input  logic                turn_cw,
    input  logic                turn_ccw,
    output snake_pkg::heading_t heading,
    output snake_pkg::heading_t step_heading
);

    import snake_pkg::*;

    logic pend_cw;      // Quarter turn right waiting for the next move
    logic pend_ccw;     // Quarter turn left waiting for the next move

    // Rotate the current heading by the pending turn
    always_comb begin
        if (pend_cw) begin
            step_heading = heading_t'(heading + 2'd1);
        end else if (pend_ccw) begin
            step_heading = heading_t'(heading - 2'd1);
        end else begin
            step_heading = heading;
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            heading  <= HEAD_RIGHT;
            pend_cw  <= 1'b0;
            pend_ccw <= 1'b0;
        end else if (sync_reset) begin
            heading  <= HEAD_RIGHT;
            pend_cw  <= 1'b0;
            pend_ccw <= 1'b0;
        end else begin
            if (move_en) begin
                heading <= step_heading;
            end
            // A new press replaces any earlier one, both together cancel
            if (steer_en && (turn_cw || turn_ccw)) begin
                pend_cw  <= turn_cw & ~turn_ccw;
                pend_ccw <= turn_ccw & ~turn_cw;
            end else if (move_en) begin
                pend_cw  <= 1'b0;       // Turn has been used by this move
                pend_ccw <= 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_snake_game.sv ====
/*
 * Testbench for the snake playfield controller. Plays scripted games through
 * the buttons and the game tick, and checks the DUT against a reference model.
 */
`timescale 1ns/100ps

module tb_snake_game;

    import snake_pkg::*;

    logic               clock_25;
    logic               reset;
    logic               game_tik;
    logic               right_p;
    logic               left_p;
    logic [LENGTH_BITS-1:0] body_index;
    logic               start;
    logic               game_over;
    score_t             score;
    cell_t              head_x;
    cell_t              head_y;
    cell_t              fruit_x;
    cell_t              fruit_y;
    cell_t              body_x;
    cell_t              body_y;
    length_t            snake_length;
    heading_t           heading;

    // Reference model state
    int       m_head_x;
    int       m_head_y;
    int       m_body_x [BODY_SLOTS];
    int       m_body_y [BODY_SLOTS];
    int       m_len;
    int       m_score;
    int       m_fruit_x;
    int       m_fruit_y;
    int       m_pending;            // +1 clockwise, -1 counter-clockwise
    heading_t m_heading;
    bit       m_start;
    bit       m_over;
    bit       fruit_new;            // Fruit was just redrawn and needs a placement check

    logic [31:0] lfsr_state = 32'he8b1_9166;
    int          check_req = 0;
    int          check_ack = 0;

    snake_game_top u_snake_game_top (
        .clock_25     (clock_25),
        .reset        (reset),
        .game_tik     (game_tik),
        .right_p      (right_p),
        .left_p       (left_p),
        .body_index   (body_index),
        .start        (start),
        .game_over    (game_over),
        .score        (score),
        .head_x       (head_x),
        .head_y       (head_y),
        .fruit_x      (fruit_x),
        .fruit_y      (fruit_y),
        .body_x       (body_x),
        .body_y       (body_y),
        .snake_length (snake_length),
        .heading      (heading)
    );

    initial begin
        clock_25 = 1'b0;
        forever #2 clock_25 = ~clock_25;
    end

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic report_error(input string msg);
        $display("ERR @ %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        stop_with_failure();
    endtask

    task automatic check_cell(input string what, input cell_t got, input cell_t exp);
        if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_heading(input heading_t got, input heading_t exp);
        if (got !== exp)
            report_error($sformatf("heading is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_length(input length_t got, input length_t exp);
        if (got !== exp) report_error($sformatf("length is %0d, expected %0d", got, exp));
    endtask

    task automatic check_score(input score_t got, input score_t exp);
        if (got !== exp) report_error($sformatf("score is %0d, expected %0d", got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    // Clockwise is one step forward in the enum order
    function automatic heading_t rotate(input heading_t h, input int turn);
        return heading_t'((int'(h) + turn + 4) % 4);
    endfunction

    function automatic void model_reset();
        m_head_x  = START_HEAD_X;
        m_head_y  = START_HEAD_Y;
        m_len     = START_LENGTH;
        m_score   = 0;
        m_fruit_x = START_FRUIT_X;
        m_fruit_y = START_FRUIT_Y;
        m_pending = 0;
        m_heading = HEAD_RIGHT;
        m_start   = 1'b0;
        m_over    = 1'b0;
        fruit_new = 1'b0;
        for (int i = 0; i < BODY_SLOTS; i++) begin
            m_body_x[i] = (i < START_LENGTH - 1) ? START_HEAD_X - 1 - i : int'(BODY_EMPTY);
            m_body_y[i] = (i < START_LENGTH - 1) ? START_HEAD_Y : int'(BODY_EMPTY);
        end
    endfunction

    function automatic void model_turn(input bit cw, input bit ccw);
        if (cw && ccw) m_pending = 0;       // Both at once cancel
        else if (cw) m_pending = 1;
        else if (ccw) m_pending = -1;
    endfunction

    // Next head, heading and body for one tick; returns 1 when the fruit is eaten
    function automatic bit model_move();
        int       nx;
        int       ny;
        int       live;
        bit       off;
        heading_t step;
        step = rotate(m_heading, m_pending);
        nx   = m_head_x;
        ny   = m_head_y;
        case (step)
            HEAD_RIGHT: nx++;
            HEAD_DOWN:  ny++;
            HEAD_LEFT:  nx--;
            default:    ny--;
        endcase
        off       = (nx < 0) || (nx >= GRID_W) || (ny < 0) || (ny >= GRID_H);
        m_heading = step;
        m_pending = 0;
        live      = m_len - 1;
        if (!off) begin
            for (int i = live - 1; i > 0; i--) begin
                m_body_x[i] = m_body_x[i-1];
                m_body_y[i] = m_body_y[i-1];
            end
            m_body_x[0] = m_head_x;
            m_body_y[0] = m_head_y;
            m_head_x    = nx;
            m_head_y    = ny;
        end
        m_over = off;
        for (int i = 0; i < live; i++) begin
            if (m_body_x[i] == m_head_x && m_body_y[i] == m_head_y) m_over = 1'b1;
        end
        if (m_over) begin
            m_start = 1'b0;
            return 1'b0;
        end
        if (m_head_x == m_fruit_x && m_head_y == m_fruit_y) begin
            m_score = (m_score == SCORE_WRAP) ? 0 : m_score + 1;
            if (m_len < LENGTH_MAX) m_len++;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // Full readback of the DUT, body slots through body_index
    task automatic compare_state();
        int live;
        int last;
        live = m_len - 1;
        last = (live < BODY_SLOTS) ? live : BODY_SLOTS - 1;
        for (int i = 0; i <= last; i++) begin
            if (i > 0) @(negedge clock_25);
            body_index = i[LENGTH_BITS-1:0];
            #1;                                 // Midway to the next rising edge
            if (i == 0) begin
                check_cell("head x", head_x, cell_t'(m_head_x));
                check_cell("head y", head_y, cell_t'(m_head_y));
                check_cell("fruit x", fruit_x, cell_t'(m_fruit_x));
                check_cell("fruit y", fruit_y, cell_t'(m_fruit_y));
                check_heading(heading, m_heading);
                check_length(snake_length, length_t'(m_len));
                check_score(score, score_t'(m_score));
                check_flag("start", start, m_start);
                check_flag("game_over", game_over, m_over);
            end
            check_cell($sformatf("body x slot %0d", i), body_x,
                       (i < live) ? cell_t'(m_body_x[i]) : BODY_EMPTY);
            check_cell($sformatf("body y slot %0d", i), body_y,
                       (i < live) ? cell_t'(m_body_y[i]) : BODY_EMPTY);
            if (fruit_new && i < live && body_x == fruit_x && body_y == fruit_y)
                report_error($sformatf("new fruit lies on body slot %0d", i));
        end
        if (fruit_new) begin
            if (m_fruit_x < 2 || m_fruit_x > GRID_W - 2 || m_fruit_y < 2 || m_fruit_y > GRID_H - 2)
                report_error($sformatf("new fruit (%0d,%0d) is outside the play area",
                                       m_fruit_x, m_fruit_y));
            if (m_fruit_x == m_head_x && m_fruit_y == m_head_y)
                report_error("new fruit lies on the head");
            fruit_new = 1'b0;
        end
    endtask

    initial begin : compare_process
        forever begin
            @(negedge clock_25);
            if (check_ack != check_req) begin
                compare_state();
                check_ack = check_req;
            end
        end
    end

    task automatic request_compare();
        int waited;
        waited = 0;
        check_req++;
        while (check_ack != check_req) begin
            @(negedge clock_25);
            waited++;
            if (waited > 300) timeout_fail("the state compare to finish");
        end
    endtask

    task automatic idle_gap();
        repeat (take_bits(2)) @(negedge clock_25);
    endtask

    task automatic wait_for_start(input logic level);
        int waited;
        waited = 0;
        while (start !== level) begin
            @(negedge clock_25);
            waited++;
            if (waited > 50) timeout_fail("start to change");
        end
    endtask

    task automatic wait_for_game_over(input logic level);
        int waited;
        waited = 0;
        while (game_over !== level) begin
            @(negedge clock_25);
            waited++;
            if (waited > 50) timeout_fail("game_over to change");
        end
    endtask

    task automatic wait_fruit_stable();
        cell_t px;
        cell_t py;
        int    waited;
        bit    stable;
        px     = fruit_x;
        py     = fruit_y;
        waited = 0;
        stable = 1'b0;
        while (!stable) begin
            @(negedge clock_25);
            stable = (fruit_x == px) && (fruit_y == py);    // Redraws change it every cycle
            px = fruit_x;
            py = fruit_y;
            waited++;
            if (waited > 300) timeout_fail("the fruit placement to settle");
        end
    endtask

    // Press and release; the edge detector gives one pulse per press
    task automatic press(input bit cw, input bit ccw);
        idle_gap();
        @(negedge clock_25);
        right_p = cw;
        left_p  = ccw;
        repeat (4) @(negedge clock_25);
        right_p = 1'b0;
        left_p  = 1'b0;
        repeat (4) @(negedge clock_25);
    endtask

    task automatic do_move();
        int old_x;
        int old_y;
        int old_score;
        int old_len;
        bit ate;
        old_x     = m_head_x;
        old_y     = m_head_y;
        old_score = m_score;
        old_len   = m_len;
        ate       = model_move();
        idle_gap();
        @(negedge clock_25);
        game_tik = 1'b1;
        @(negedge clock_25);
        game_tik = 1'b0;
        check_cell("head x before the update", head_x, cell_t'(old_x));
        check_cell("head y before the update", head_y, cell_t'(old_y));
        @(negedge clock_25);                    // Head updates 2 cycles after the tick
        check_cell("head x after the tick", head_x, cell_t'(m_head_x));
        check_cell("head y after the tick", head_y, cell_t'(m_head_y));
        @(negedge clock_25);
        check_flag("game_over", game_over, m_over);
        check_flag("start", start, m_start);
        if (ate) begin
            check_score(score, score_t'(old_score));
            check_length(snake_length, length_t'(old_len));
            @(negedge clock_25);
            check_score(score, score_t'(m_score));
            check_length(snake_length, length_t'(m_len));
            wait_fruit_stable();
            m_fruit_x = fruit_x;
            m_fruit_y = fruit_y;
            fruit_new = 1'b1;
        end
        request_compare();
    endtask

    initial begin : stimulus
        int moves;
        reset      = 1'b0;
        game_tik   = 1'b0;
        right_p    = 1'b0;
        left_p     = 1'b0;
        body_index = '0;
        model_reset();
        repeat (5) @(negedge clock_25);
        reset = 1'b1;
        @(negedge clock_25);
        request_compare();                      // Reset values

        // Start press in IDLE does not turn
        press(1'b1, 1'b0);
        wait_for_start(1'b1);
        m_start = 1'b1;
        request_compare();
        repeat (10) do_move();

        // Turn down and reach the start fruit at (18,50)
        press(1'b1, 1'b0);
        model_turn(1'b1, 1'b0);
        repeat (10) do_move();
        check_score(score, score_t'(1));
        check_length(snake_length, length_t'(START_LENGTH + 1));

        press(1'b0, 1'b1);                      // Back to the right
        model_turn(1'b0, 1'b1);
        do_move();
        press(1'b1, 1'b1);                      // Cancelled turn
        model_turn(1'b1, 1'b1);
        do_move();

        // Down into the bottom wall
        press(1'b1, 1'b0);
        model_turn(1'b1, 1'b0);
        moves = 0;
        while (!m_over) begin
            do_move();
            moves++;
            if (moves > 40) timeout_fail("the wall collision");
        end
        check_cell("head y at the wall", head_y, cell_t'(GRID_H - 1));

        // Restart restores the reset values
        press(1'b1, 1'b0);
        wait_for_game_over(1'b0);
        @(negedge clock_25);
        model_reset();
        request_compare();

        // Three right turns bring the head back onto the body
        press(1'b1, 1'b0);
        wait_for_start(1'b1);
        m_start = 1'b1;
        request_compare();
        repeat (3) do_move();
        repeat (3) begin
            press(1'b1, 1'b0);
            model_turn(1'b1, 1'b0);
            do_move();
        end
        check_flag("game_over after the self collision", game_over, 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/snake_pkg.sv
rtl/button_edge.sv
rtl/steer_control.sv
rtl/snake_body.sv
rtl/fruit_placer.sv
rtl/game_fsm.sv
rtl/snake_game_top.sv
sim/tb_snake_game.sv
